/* design/nf_bus_pkg.sv */
/*
 * Bus-level definitions for the peripheral subsystem
 * - address and data widths of the host bus
 * - address map and slave select field
 * - slave-select enum
 */

`default_nettype none

package nf_bus_pkg;

    localparam int nf_addr_w = 32;
    localparam int nf_data_w = 32;

    // number of real slaves behind the router
    localparam int nf_slave_n = 3;

    // slave select field in the address
    localparam int nf_sel_hi = 17;
    localparam int nf_sel_lo = 16;

    // byte offset bits below the word address
    localparam int nf_word_lsb = 2;

    // base addresses of the slaves
    localparam logic [nf_addr_w-1:0] nf_ram_base  = 32'h0000_0000;
    localparam logic [nf_addr_w-1:0] nf_gpio_base = 32'h0001_0000;
    localparam logic [nf_addr_w-1:0] nf_pwm_base  = 32'h0002_0000;

    // slv_none has no slave behind it, reads give 0
    typedef enum logic [1:0] {
        slv_ram  = 2'd0,
        slv_gpio = 2'd1,
        slv_pwm  = 2'd2,
        slv_none = 2'd3
    } nf_slave_e;

endpackage : nf_bus_pkg

`default_nettype wire

/* design/nf_gpio.sv */
/*
 * GPIO slave
 * - two-flop input synchronizer
 * - output value and direction registers
 * - registered readback by offset
 */

`timescale 1ns/1ps
`default_nettype none

module nf_gpio #(
    parameter int gpio_w = nf_periph_pkg::nf_gpio_w_dflt
) (
    input  logic                             clk,
    input  logic                             rst_n,
    // router side
    input  logic [nf_bus_pkg::nf_addr_w-1:0] addr,
    input  logic                             we,
    input  logic [nf_bus_pkg::nf_data_w-1:0] wd,
    output logic [nf_bus_pkg::nf_data_w-1:0] rd,
    // pin side
    input  logic [gpio_w-1:0]                gpi,
    output logic [gpio_w-1:0]                gpo,
    output logic [gpio_w-1:0]                gpd
);

    import nf_bus_pkg::*;
    import nf_periph_pkg::*;

    nf_gpio_reg_e      reg_sel;
    logic [gpio_w-1:0] gpi_meta;
    logic [gpio_w-1:0] gpi_sync;

    assign reg_sel = nf_gpio_reg_e'(addr[3:2]);

    // pins are asynchronous to clk
    always_ff @(posedge clk) begin
        gpi_meta <= gpi;
        gpi_sync <= gpi_meta;
    end

    // all pins come up as inputs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpo <= '0;
            gpd <= '0;
        end else if (we) begin
            case (reg_sel)
                gpio_gpo: gpo <= wd[gpio_w-1:0];
                gpio_gpd: gpd <= wd[gpio_w-1:0];
                default:  ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (reg_sel)
            gpio_gpi: rd <= nf_data_w'(gpi_sync);
            gpio_gpo: rd <= nf_data_w'(gpo);
            gpio_gpd: rd <= nf_data_w'(gpd);
            default:  rd <= '0;
        endcase
    end

endmodule : nf_gpio

`default_nettype wire

/* design/nf_periph_pkg.sv */
/*
 * Peripheral definitions
 * - GPIO register offsets
 * - PWM register offsets
 * - default widths and RAM depth
 */

`default_nettype none

package nf_periph_pkg;

    // GPIO registers, selected by address bits 3:2
    typedef enum logic [1:0] {
        gpio_gpi = 2'b00,
        gpio_gpo = 2'b01,
        gpio_gpd = 2'b10
    } nf_gpio_reg_e;

    // PWM registers, selected by address bit 2
    typedef enum logic {
        pwm_cmp = 1'b0,
        pwm_cnt = 1'b1
    } nf_pwm_reg_e;

    localparam int nf_gpio_w_dflt    = 8;
    localparam int nf_pwm_w_dflt     = 8;
    localparam int nf_ram_depth_dflt = 64;

    // width of the prescaler divider input
    localparam int nf_div_w = 26;

endpackage : nf_periph_pkg

`default_nettype wire

/* design/nf_pwm.sv */
/*
 * PWM slave
 * - prescaler strobe every div+1 clocks
 * - free-running counter and compare register
 * - registered output and readback
 */

`timescale 1ns/1ps
`default_nettype none

module nf_pwm #(
    parameter int pwm_w = nf_periph_pkg::nf_pwm_w_dflt
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [nf_periph_pkg::nf_div_w-1:0]  div,
    // router side
    input  logic [nf_bus_pkg::nf_addr_w-1:0]    addr,
    input  logic                                we,
    input  logic [nf_bus_pkg::nf_data_w-1:0]    wd,
    output logic [nf_bus_pkg::nf_data_w-1:0]    rd,
    output logic                                pwm
);

    import nf_bus_pkg::*;
    import nf_periph_pkg::*;

    typedef enum logic {
        pwm_low,
        pwm_high
    } pwm_state_e;

    nf_pwm_reg_e       reg_sel;
    pwm_state_e        state;
    logic [nf_div_w-1:0] presc;
    logic              strobe;
    logic [pwm_w-1:0]  cnt;
    logic [pwm_w-1:0]  cmp;

    assign reg_sel = nf_pwm_reg_e'(addr[2]);
    assign strobe  = (presc == div);

    // prescaler, restarts after reaching div
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            presc <= '0;
        end else if (strobe) begin
            presc <= '0;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    // counter wraps naturally at 2^pwm_w
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (strobe) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmp <= '0;
        end else if (we && (reg_sel == pwm_cmp)) begin
            cmp <= wd[pwm_w-1:0];
        end
    end

    // high while the counter is below compare
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= pwm_low;
        end else begin
            state <= (cnt < cmp) ? pwm_high : pwm_low;
        end
    end

    assign pwm = (state == pwm_high);

    always_ff @(posedge clk) begin
        case (reg_sel)
            pwm_cmp: rd <= nf_data_w'(cmp);
            default: rd <= nf_data_w'(cnt);
        endcase
    end

endmodule : nf_pwm

`default_nettype wire

/* design/nf_ram.sv */
/*
 * Word RAM slave
 * - synchronous write, registered read
 * - word address wraps modulo the depth
 */

`timescale 1ns/1ps
`default_nettype none

module nf_ram #(
    parameter int ram_depth = nf_periph_pkg::nf_ram_depth_dflt
) (
    input  logic                             clk,
    input  logic [nf_bus_pkg::nf_addr_w-1:0] addr,
    input  logic                             we,
    input  logic [nf_bus_pkg::nf_data_w-1:0] wd,
    output logic [nf_bus_pkg::nf_data_w-1:0] rd
);

    import nf_bus_pkg::*;

    localparam int ram_aw = $clog2(ram_depth);

    logic [nf_data_w-1:0] mem [ram_depth];
    logic [ram_aw-1:0]    idx;

    // word index, upper bits dropped for the wrap
    assign idx = addr[nf_word_lsb +: ram_aw];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wd;
        end
    end

    // read before write on the same edge
    always_ff @(posedge clk) begin
        rd <= mem[idx];
    end

endmodule : nf_ram

`default_nettype wire

/* design/nf_router.sv */
/*
 * Host bus router
 * - address decode onto the slave-select enum
 * - per-slave write enable
 * - read data mux driven by the registered select
 */

`timescale 1ns/1ps
`default_nettype none

module nf_router (
    input  logic                                                         clk,
    input  logic                                                         rst_n,
    // host side
    input  logic [nf_bus_pkg::nf_addr_w-1:0]                             addr,
    input  logic                                                         we,
    input  logic [nf_bus_pkg::nf_data_w-1:0]                             wd,
    output logic [nf_bus_pkg::nf_data_w-1:0]                             rd,
    // slave side
    output logic [nf_bus_pkg::nf_addr_w-1:0]                             addr_s,
    output logic [nf_bus_pkg::nf_data_w-1:0]                             wd_s,
    output logic [nf_bus_pkg::nf_slave_n-1:0]                            we_s,
    input  logic [nf_bus_pkg::nf_slave_n-1:0][nf_bus_pkg::nf_data_w-1:0] rd_s
);

    import nf_bus_pkg::*;

    nf_slave_e sel;
    nf_slave_e sel_q;

    // address and write data go to every slave
    assign addr_s = addr;
    assign wd_s   = wd;

    always_comb begin
        case (addr[nf_sel_hi:nf_sel_lo])
            nf_ram_base[nf_sel_hi:nf_sel_lo]:  sel = slv_ram;
            nf_gpio_base[nf_sel_hi:nf_sel_lo]: sel = slv_gpio;
            nf_pwm_base[nf_sel_hi:nf_sel_lo]:  sel = slv_pwm;
            default:                           sel = slv_none;
        endcase
    end

    // only the decoded slave sees the write
    always_comb begin
        for (int i = 0; i < nf_slave_n; i++) begin
            we_s[i] = we && (sel == nf_slave_e'(i));
        end
    end

    // select follows the slaves' one-cycle read latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_q <= slv_none;
        end else begin
            sel_q <= sel;
        end
    end

    always_comb begin
        if (sel_q == slv_none) begin
            rd = '0;
        end else begin
            rd = rd_s[sel_q];
        end
    end

endmodule : nf_router

`default_nettype wire

/* design/nf_top.sv */
/*
 * Peripheral subsystem top
 * - router on the host bus
 * - RAM, GPIO and PWM slaves
 */

`timescale 1ns/1ps
`default_nettype none

module nf_top #(
    parameter int ram_depth = nf_periph_pkg::nf_ram_depth_dflt,
    parameter int gpio_w    = nf_periph_pkg::nf_gpio_w_dflt,
    parameter int pwm_w     = nf_periph_pkg::nf_pwm_w_dflt
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [nf_periph_pkg::nf_div_w-1:0] div,
    // host port
    input  logic [nf_bus_pkg::nf_addr_w-1:0]   addr,
    input  logic                               we,
    input  logic [nf_bus_pkg::nf_data_w-1:0]   wd,
    output logic [nf_bus_pkg::nf_data_w-1:0]   rd,
    // gpio pins
    input  logic [gpio_w-1:0]                  gpi,
    output logic [gpio_w-1:0]                  gpo,
    output logic [gpio_w-1:0]                  gpd,
    // pwm output
    output logic                               pwm
);

    import nf_bus_pkg::*;

    // shared slave bus
    logic [nf_addr_w-1:0]                  addr_s;
    logic [nf_data_w-1:0]                  wd_s;
    logic [nf_slave_n-1:0]                 we_s;
    logic [nf_slave_n-1:0][nf_data_w-1:0]  rd_s;

    nf_router router0 (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .addr   ( addr   ),
        .we     ( we     ),
        .wd     ( wd     ),
        .rd     ( rd     ),
        .addr_s ( addr_s ),
        .wd_s   ( wd_s   ),
        .we_s   ( we_s   ),
        .rd_s   ( rd_s   )
    );

    nf_ram #(
        .ram_depth ( ram_depth )
    ) ram0 (
        .clk  ( clk            ),
        .addr ( addr_s         ),
        .we   ( we_s[slv_ram]  ),
        .wd   ( wd_s           ),
        .rd   ( rd_s[slv_ram]  )
    );

    nf_gpio #(
        .gpio_w ( gpio_w )
    ) gpio0 (
        .clk   ( clk            ),
        .rst_n ( rst_n          ),
        .addr  ( addr_s         ),
        .we    ( we_s[slv_gpio] ),
        .wd    ( wd_s           ),
        .rd    ( rd_s[slv_gpio] ),
        .gpi   ( gpi            ),
        .gpo   ( gpo            ),
        .gpd   ( gpd            )
    );

    nf_pwm #(
        .pwm_w ( pwm_w )
    ) pwm0 (
        .clk   ( clk           ),
        .rst_n ( rst_n         ),
        .div   ( div           ),
        .addr  ( addr_s        ),
        .we    ( we_s[slv_pwm] ),
        .wd    ( wd_s          ),
        .rd    ( rd_s[slv_pwm] ),
        .pwm   ( pwm           )
    );

endmodule : nf_top

`default_nettype wire

/* files.f */
design/nf_bus_pkg.sv
design/nf_periph_pkg.sv
design/nf_router.sv
design/nf_ram.sv
design/nf_gpio.sv
design/nf_pwm.sv
design/nf_top.sv
verification/nf_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps --top-module nf_tb -f files.f -o nf_sim

./obj_dir/nf_sim | tee sim.log

if grep -qx "RESULT: PASS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

/* verification/nf_tb.sv */
/*
 * Testbench for the peripheral subsystem
 * - clock, reset and watchdog
 * - LFSR stimulus and value check
 * - directed tests: reset, RAM, GPIO, address map, PWM duty
 */

`timescale 1ns/1ps
`default_nettype none

module nf_tb;

    localparam int clk_period  = 20;
    localparam int reset_cycles = 10;
    localparam int ram_depth   = 64;
    localparam int gpio_w      = 8;
    localparam int pwm_w       = 8;
    localparam int div_val     = 1;

    localparam int ram_words   = 32;
    localparam int gpio_rounds = 4;
    localparam int pwm_rounds  = 3;
    localparam int pwm_period  = (1 << pwm_w) * (div_val + 1);

    // rough cycle budget of each test, doubled for the watchdog
    localparam int test_cycles = reset_cycles + 20 + ram_words * 6 + gpio_rounds * 24
                               + 40 + pwm_rounds * (pwm_period + 10);
    localparam int watchdog_ns = 2 * test_cycles * clk_period;

    localparam logic [15:0] lfsr_seed = 16'd65473;

    // address map of the host bus
    localparam logic [31:0] addr_ram_base = 32'h0000_0000;
    localparam logic [31:0] addr_gpio_gpi = 32'h0001_0000;
    localparam logic [31:0] addr_gpio_gpo = 32'h0001_0004;
    localparam logic [31:0] addr_gpio_gpd = 32'h0001_0008;
    localparam logic [31:0] addr_gpio_unused = 32'h0001_000C;
    localparam logic [31:0] addr_pwm_cmp  = 32'h0002_0000;
    localparam logic [31:0] addr_pwm_cnt  = 32'h0002_0004;
    localparam logic [31:0] addr_none     = 32'h0003_0000;

    logic              clk;
    logic              rst_n;
    logic [25:0]       div;
    logic [31:0]       addr;
    logic              we;
    logic [31:0]       wd;
    logic [31:0]       rd;
    logic [gpio_w-1:0] gpi;
    logic [gpio_w-1:0] gpo;
    logic [gpio_w-1:0] gpd;
    logic              pwm;

    logic [15:0]       lfsr_state;

    nf_top #(
        .ram_depth ( ram_depth ),
        .gpio_w    ( gpio_w    ),
        .pwm_w     ( pwm_w     )
    ) dut0 (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .div   ( div   ),
        .addr  ( addr  ),
        .we    ( we    ),
        .wd    ( wd    ),
        .rd    ( rd    ),
        .gpi   ( gpi   ),
        .gpo   ( gpo   ),
        .gpd   ( gpd   ),
        .pwm   ( pwm   )
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: tests did not finish within %0d ns", watchdog_ns);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s (got 0x%08h, expected 0x%08h)",
                     $time, msg, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "stopped at first failed check");
        end
    endtask

    // one-cycle write, we drops at the capturing edge
    task automatic bus_write(input logic [31:0] a, input logic [31:0] d);
        @(posedge clk);
        addr <= a;
        wd   <= d;
        we   <= 1'b1;
        @(posedge clk);
        we   <= 1'b0;
    endtask

    // data shows up one cycle after the address
    task automatic bus_read(input logic [31:0] a, output logic [31:0] d);
        @(posedge clk);
        addr <= a;
        we   <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        d = rd;
    endtask

    task automatic test_reset_state();
        logic [31:0] v;
        logic [31:0] v2;
        @(negedge clk);
        check_equal({24'd0, gpo}, 32'd0, "gpo after reset");
        check_equal({24'd0, gpd}, 32'd0, "gpd after reset");
        check_equal({31'd0, pwm}, 32'd0, "pwm after reset");
        check_equal(rd, 32'd0, "rd after reset");
        // back-to-back reads sample the counter div+1 clocks apart
        bus_read(addr_pwm_cnt, v);
        bus_read(addr_pwm_cnt, v2);
        check_equal(v2, (v + 32'd1) % (32'd1 << pwm_w), "pwm counter step");
    endtask

    task automatic test_ram();
        logic [31:0] model [ram_depth];
        logic [7:0]  word_addr [ram_words];
        logic [31:0] r;
        logic [31:0] d;
        logic [5:0]  idx;
        for (int i = 0; i < ram_words; i++) begin
            r = rand_bits(8);
            word_addr[i] = r[7:0];
            d = rand_bits(32);
            // word addresses above the depth alias
            idx = 6'(word_addr[i] % ram_depth);
            model[idx] = d;
            bus_write(addr_ram_base | {22'd0, word_addr[i], 2'b00}, d);
        end
        for (int i = 0; i < ram_words; i++) begin
            idx = 6'(word_addr[i] % ram_depth);
            bus_read(addr_ram_base | {22'd0, word_addr[i], 2'b00}, r);
            check_equal(r, model[idx], $sformatf("ram word 0x%02h", word_addr[i]));
        end
        // read in the cycle right after the write
        d = rand_bits(32);
        bus_write(addr_ram_base | {22'd0, word_addr[0], 2'b00}, d);
        @(posedge clk);
        @(negedge clk);
        check_equal(rd, d, "ram read right after write");
    endtask

    task automatic test_gpio();
        logic [31:0] r;
        logic [31:0] v;
        for (int i = 0; i < gpio_rounds; i++) begin
            r = rand_bits(gpio_w);
            bus_write(addr_gpio_gpo, r);
            @(negedge clk);
            check_equal({24'd0, gpo}, r, "gpo pins");
            bus_read(addr_gpio_gpo, v);
            check_equal(v, r, "gpo readback");
            r = rand_bits(gpio_w);
            bus_write(addr_gpio_gpd, r);
            @(negedge clk);
            check_equal({24'd0, gpd}, r, "gpd pins");
            bus_read(addr_gpio_gpd, v);
            check_equal(v, r, "gpd readback");
            // input passes two sync flops before the read register
            r = rand_bits(gpio_w);
            @(posedge clk);
            gpi <= r[gpio_w-1:0];
            repeat (3) @(posedge clk);
            bus_read(addr_gpio_gpi, v);
            check_equal(v, r, "gpi readback");
        end
        bus_read(addr_gpio_unused, v);
        check_equal(v, 32'd0, "gpio unused offset");
    endtask

    task automatic test_addr_map();
        logic [31:0] ram0_val;
        logic [31:0] gpo_val;
        logic [31:0] cmp_val;
        logic [31:0] v;
        ram0_val = rand_bits(32);
        gpo_val  = rand_bits(gpio_w);
        cmp_val  = rand_bits(pwm_w);
        bus_write(addr_ram_base, ram0_val);
        bus_write(addr_gpio_gpo, gpo_val);
        bus_write(addr_pwm_cmp, cmp_val);
        // these must land nowhere
        bus_write(addr_none, rand_bits(32));
        bus_write(addr_none + 32'd4, rand_bits(32));
        bus_write(32'hFFFF_FFFC, rand_bits(32));
        bus_read(addr_none, v);
        check_equal(v, 32'd0, "read at unmapped slot");
        bus_read(32'hFFFF_FFFC, v);
        check_equal(v, 32'd0, "read at unmapped top address");
        bus_read(addr_ram_base, v);
        check_equal(v, ram0_val, "ram word 0 after unmapped writes");
        bus_read(addr_gpio_gpo, v);
        check_equal(v, gpo_val, "gpo after unmapped writes");
        check_equal({24'd0, gpo}, gpo_val, "gpo pins after unmapped writes");
        bus_read(addr_pwm_cmp, v);
        check_equal(v, cmp_val, "pwm compare after unmapped writes");
    endtask

    task automatic test_pwm_duty(input logic [7:0] cmp_val);
        int          hi_count;
        logic [31:0] v;
        hi_count = 0;
        bus_write(addr_pwm_cmp, {24'd0, cmp_val});
        bus_read(addr_pwm_cmp, v);
        check_equal(v, {24'd0, cmp_val}, "pwm compare readback");
        // output is periodic, so any window of one full wrap works
        repeat (pwm_period) begin
            @(negedge clk);
            if (pwm) begin
                hi_count++;
            end
        end
        check_equal(hi_count, cmp_val * (div_val + 1),
                    $sformatf("pwm high cycles for cmp %0d", cmp_val));
    endtask

    initial begin
        logic [31:0] r;
        rst_n      = 1'b0;
        div        = 26'(div_val);
        addr       = addr_none;
        we         = 1'b0;
        wd         = '0;
        gpi        = '0;
        lfsr_state = lfsr_seed;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        test_reset_state();
        test_ram();
        test_gpio();
        test_addr_map();
        for (int i = 0; i < pwm_rounds - 1; i++) begin
            r = rand_bits(pwm_w);
            test_pwm_duty(r[7:0]);
        end
        // zero compare keeps the output low
        test_pwm_duty(8'd0);

        $display("RESULT: PASS");
        $finish;
    end

endmodule : nf_tb

`default_nettype wire
